//--- hdl/apb_pkg.sv
// apb package
// request bundle, bus widths and register map of the settings port
`default_nettype none

package apb_pkg;

  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // master to slave signals of one apb access
  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  // register map, byte offsets
  localparam apb_addr_t CFG_OFS  = 8'h00; // sys_cfg_t in bits 5..0
  localparam apb_addr_t HID_OFS  = 8'h04; // mouse 5..0, joystick 12..8
  localparam apb_addr_t KBD_BASE = 8'h10; // row i at KBD_BASE + 4*i

  // field positions inside the hid word
  localparam int HID_MOUSE_LSB = 0;
  localparam int HID_JOY_LSB   = 8;

endpackage

`default_nettype wire

//--- hdl/apb_regs.sv
// apb register slave
// holds the menu settings, usb hid mouse/joystick state and the
// fifteen keyboard matrix rows written by the mcu
`timescale 1ns/1ns
`default_nettype none

module apb_regs
  import apb_pkg::*;
  import st_cfg_pkg::*;
(
  input  logic      clk32,
  input  logic      rst,
  input  apb_req_t  apb,
  output apb_data_t prdata,
  output logic      pready,
  output logic      pslverr,
  output sys_cfg_t  cfg,
  output port6_t    hid_mouse,
  output joy5_t     hid_joy,
  output kbd_row_t  kbd_rows [KBD_ROWS]
);

  // first byte past the last keyboard row
  localparam apb_addr_t KBD_END = KBD_BASE + apb_addr_t'(4 * KBD_ROWS);

  logic      access;  // second cycle of an apb transfer
  logic      cfg_hit;
  logic      hid_hit;
  logic      kbd_hit;
  apb_addr_t kbd_ofs;
  logic [3:0] kbd_idx;
  apb_data_t rd_data;

  assign access = apb.psel && apb.penable;

  // address decode
  assign cfg_hit = (apb.paddr == CFG_OFS);
  assign hid_hit = (apb.paddr == HID_OFS);
  assign kbd_ofs = apb.paddr - KBD_BASE;
  assign kbd_idx = 4'(kbd_ofs >> 2); // word index into row array
  assign kbd_hit = (apb.paddr >= KBD_BASE) && (apb.paddr < KBD_END) &&
                   (apb.paddr[1:0] == 2'b00); // word aligned only

  // writes land at the edge that closes the access phase
  always_ff @(posedge clk32) begin
    if (rst) begin
      cfg.mouse_port <= MP_USB;
      cfg.volume     <= VOL_FULL;
      cfg.sys_reset  <= 1'b0;
      cfg.coldboot   <= 1'b0;
      hid_mouse      <= '0;
      hid_joy        <= '0;
      for (int i = 0; i < KBD_ROWS; i++) begin
        kbd_rows[i] <= 8'hFF; // all keys released
      end
    end else if (access && apb.pwrite) begin
      if (cfg_hit) begin
        cfg <= sys_cfg_t'(apb.pwdata[5:0]);
      end
      if (hid_hit) begin
        hid_mouse <= apb.pwdata[HID_MOUSE_LSB +: 6];
        hid_joy   <= apb.pwdata[HID_JOY_LSB +: 5];
      end
      if (kbd_hit) begin
        kbd_rows[kbd_idx] <= apb.pwdata[7:0];
      end
    end
  end

  // read mux, unmapped reads as zero
  always_comb begin
    rd_data = '0;
    if (cfg_hit) begin
      rd_data[5:0] = cfg;
    end else if (hid_hit) begin
      rd_data[HID_MOUSE_LSB +: 6] = hid_mouse;
      rd_data[HID_JOY_LSB +: 5]   = hid_joy;
    end else if (kbd_hit) begin
      rd_data[7:0] = kbd_rows[kbd_idx];
    end
  end

  assign prdata  = access ? rd_data : '0; // only driven in access phase
  assign pready  = 1'b1;                   // no wait states
  assign pslverr = access && !(cfg_hit || hid_hit || kbd_hit);

endmodule

`default_nettype wire

//--- hdl/audio_volume.sv
// audio volume
// widens chipset audio to 16 bit and scales it by the menu volume
`timescale 1ns/1ns
`default_nettype none

module audio_volume
  import st_cfg_pkg::*;
(
  input  logic      clk32,
  input  logic      rst,
  input  volume_e   volume,
  input  sample15_t audio_l_in,
  input  sample15_t audio_r_in,
  output sample16_t audio_l,
  output sample16_t audio_r
);

  // sign extend, then arithmetic shift for the volume step
  function automatic sample16_t scale(input sample15_t s, input volume_e v);
    sample16_t ext;
    ext = {s[14], s};
    case (v)
      VOL_MUTE:    return '0;
      VOL_QUARTER: return {{2{ext[15]}}, ext[15:2]}; // /4
      VOL_HALF:    return {ext[15], ext[15:1]};      // /2
      default:     return ext;
    endcase
  endfunction

  // one cycle latency on both channels
  always_ff @(posedge clk32) begin
    if (rst) begin
      audio_l <= '0;
      audio_r <= '0;
    end else begin
      audio_l <= scale(audio_l_in, volume);
      audio_r <= scale(audio_r_in, volume);
    end
  end

endmodule

`default_nettype wire

//--- hdl/boot_control.sv
// boot control
// waits for the sd card image, gates the st reset and scrambles
// ram addresses on every coldboot request
`timescale 1ns/1ns
`default_nettype none

module boot_control
  import st_cfg_pkg::*;
#(
  parameter int unsigned SD_WAIT_CYCLES = 64000000 // max wait for an sd image
) (
  input  logic        clk32,
  input  logic        rst,
  input  sys_cfg_t    cfg,
  input  logic        reset_button,
  input  logic        ram_ready,
  input  logic        flash_ready,
  input  logic [31:0] sd_img_size,
  input  word_addr_t  ram_addr_in,
  output logic        st_resb,
  output logic        sd_ready,
  output word_addr_t  ram_addr_out
);

  localparam int WAIT_W = $clog2(SD_WAIT_CYCLES + 1);

  logic [WAIT_W-1:0] sd_wait;  // cycles since reset
  logic              cb_d;     // coldboot, one cycle late
  logic [1:0]        scramble;

  // give the mcu time to mount a default image before boot
  always_ff @(posedge clk32) begin
    if (rst) begin
      sd_wait  <= '0;
      sd_ready <= 1'b0;
    end else if (!sd_ready) begin
      if (sd_img_size != 32'd0) begin
        sd_ready <= 1'b1; // image mounted
      end
      if (sd_wait < WAIT_W'(SD_WAIT_CYCLES)) begin
        sd_wait <= sd_wait + 1'b1;
      end else begin
        sd_ready <= 1'b1; // timeout, boot anyway
      end
    end
  end

  // count coldboot rising edges
  always_ff @(posedge clk32) begin
    if (rst) begin
      cb_d     <= 1'b0;
      scramble <= 2'd0;
    end else begin
      cb_d <= cfg.coldboot;
      if (cfg.coldboot && !cb_d) begin
        scramble <= scramble + 2'd1;
      end
    end
  end

  // run the st only once everything below it is up
  assign st_resb = !cfg.sys_reset && !reset_button &&
                   ram_ready && flash_ready && sd_ready;

  // old ram contents look like garbage after a cold boot
  assign ram_addr_out = {ram_addr_in[22:5], ram_addr_in[4:3] ^ scramble, ram_addr_in[2:0]};

endmodule

`default_nettype wire

//--- hdl/input_mapper.sv
// input mapper
// picks the mouse source for joy0, merges db9 into joy1 and
// reads the keyboard matrix columns for the selected rows
`timescale 1ns/1ns
`default_nettype none

module input_mapper
  import st_cfg_pkg::*;
(
  input  mouse_port_e mouse_port,
  input  port6_t      hid_mouse,
  input  joy5_t       hid_joy,
  input  logic [7:0]  io,       // db9 pins, active low
  input  kbd_row_t    kbd_rows [KBD_ROWS],
  input  kbd_sel_t    kbd_sel,  // row strobes from ikbd, active low
  output port6_t      joy0,
  output joy5_t       joy1,
  output kbd_row_t    kbd_cols
);

  port6_t db9_atari;
  port6_t db9_amiga;
  port6_t db9_joy;

  // same db9 pins, two wiring orders
  assign db9_atari = ~{io[5], io[0], io[2], io[1], io[4], io[3]};
  assign db9_amiga = ~{io[5], io[0], io[3], io[1], io[4], io[2]};

  // a db9 mouse replaces the usb one, mice hold lines active
  always_comb begin
    case (mouse_port)
      MP_USB:       joy0 = hid_mouse;
      MP_DB9_ATARI: joy0 = db9_atari;
      MP_DB9_AMIGA: joy0 = db9_amiga;
      default:      joy0 = '0; // port disabled
    endcase
  end

  // db9 acts as joystick only while the mouse is on usb
  assign db9_joy = (mouse_port == MP_USB) ? db9_atari : '0;
  assign joy1    = hid_joy | db9_joy[4:0]; // wired-or of both sources

  // pressed keys pull low, selected rows combine by and
  always_comb begin
    kbd_cols = 8'hFF;
    for (int i = 0; i < KBD_ROWS; i++) begin
      if (!kbd_sel[i]) begin
        kbd_cols = kbd_cols & kbd_rows[i];
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/st_cfg_pkg.sv
// st config package
// types and setting codes shared by the atari st glue blocks
`default_nettype none

package st_cfg_pkg;

  // mouse port source, as picked in the on-screen menu
  typedef enum logic [1:0] {
    MP_USB       = 2'd0,
    MP_DB9_ATARI = 2'd1,
    MP_DB9_AMIGA = 2'd2,
    MP_NONE      = 2'd3
  } mouse_port_e;

  typedef enum logic [1:0] {
    VOL_MUTE    = 2'd0,
    VOL_QUARTER = 2'd1, // -12 dB
    VOL_HALF    = 2'd2, // -6 dB
    VOL_FULL    = 2'd3
  } volume_e;

  // menu settings, msb first
  typedef struct packed {
    mouse_port_e mouse_port;
    volume_e     volume;
    logic        sys_reset; // hold the st in reset
    logic        coldboot;  // rising edge scrambles ram
  } sys_cfg_t;

  typedef logic [5:0]  port6_t;     // up/down/left/right + 2 buttons
  typedef logic [4:0]  joy5_t;      // directions + fire
  typedef logic [7:0]  kbd_row_t;   // active low key bits
  typedef logic [14:0] kbd_sel_t;   // active low row strobes
  typedef logic [14:0] sample15_t;  // signed, from chipset mixer
  typedef logic [15:0] sample16_t;  // signed, to dac
  typedef logic [22:0] word_addr_t; // st ram word address

  localparam int KBD_ROWS = 15;

endpackage

`default_nettype wire

//--- hdl/st_glue_top.sv
// atari st glue top
// settings registers, input mapping, audio scaling and boot control
`timescale 1ns/1ns
`default_nettype none

module st_glue_top
  import apb_pkg::*;
  import st_cfg_pkg::*;
#(
  parameter int unsigned SD_WAIT_CYCLES = 64000000 // 2 s at 32 MHz
) (
  input  logic        clk32,
  input  logic        rst,
  // apb settings port from the mcu
  input  apb_req_t    apb,
  output apb_data_t   prdata,
  output logic        pready,
  output logic        pslverr,
  // input devices
  input  logic [7:0]  io,      // db9 port
  input  kbd_sel_t    kbd_sel,
  output port6_t      joy0,
  output joy5_t       joy1,
  output kbd_row_t    kbd_cols,
  // audio
  input  sample15_t   audio_l_in,
  input  sample15_t   audio_r_in,
  output sample16_t   audio_l,
  output sample16_t   audio_r,
  // boot
  input  logic        reset_button,
  input  logic        ram_ready,
  input  logic        flash_ready,
  input  logic [31:0] sd_img_size,
  input  word_addr_t  ram_addr_in,
  output logic        st_resb,
  output logic        sd_ready,
  output word_addr_t  ram_addr_out
);

  sys_cfg_t cfg;                 // menu settings, fan out to all blocks
  port6_t   hid_mouse;
  joy5_t    hid_joy;
  kbd_row_t kbd_rows [KBD_ROWS]; // matrix image kept by the mcu

  apb_regs u_regs (
    .clk32    (clk32),
    .rst      (rst),
    .apb      (apb),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .cfg      (cfg),
    .hid_mouse(hid_mouse),
    .hid_joy  (hid_joy),
    .kbd_rows (kbd_rows)
  );

  input_mapper u_input (
    .mouse_port(cfg.mouse_port),
    .hid_mouse (hid_mouse),
    .hid_joy   (hid_joy),
    .io        (io),
    .kbd_rows  (kbd_rows),
    .kbd_sel   (kbd_sel),
    .joy0      (joy0),
    .joy1      (joy1),
    .kbd_cols  (kbd_cols)
  );

  audio_volume u_audio (
    .clk32     (clk32),
    .rst       (rst),
    .volume    (cfg.volume),
    .audio_l_in(audio_l_in),
    .audio_r_in(audio_r_in),
    .audio_l   (audio_l),
    .audio_r   (audio_r)
  );

  boot_control #(
    .SD_WAIT_CYCLES(SD_WAIT_CYCLES)
  ) u_boot (
    .clk32       (clk32),
    .rst         (rst),
    .cfg         (cfg),
    .reset_button(reset_button),
    .ram_ready   (ram_ready),
    .flash_ready (flash_ready),
    .sd_img_size (sd_img_size),
    .ram_addr_in (ram_addr_in),
    .st_resb     (st_resb),
    .sd_ready    (sd_ready),
    .ram_addr_out(ram_addr_out)
  );

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# build and run the st glue testbench with verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f tb.f
./obj_dir/Vtb_top | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"

//--- tb.f
+incdir+testbench
hdl/st_cfg_pkg.sv
hdl/apb_pkg.sv
hdl/apb_regs.sv
hdl/input_mapper.sv
hdl/audio_volume.sv
hdl/boot_control.sv
hdl/st_glue_top.sv
testbench/tb_top.sv

//--- testbench/tb_model.svh
// reference model for the st glue testbench
// db9 decode, keyboard scan, volume and scramble rules, plus apb master tasks
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam int BUS_TIMEOUT = 16; // cycles to wait for pready

// db9 pins are active low, pin_of lists the pin for bit 0 up to bit 5
function automatic port6_t db9_decode(input logic [7:0] pins, input bit amiga);
  int pin_of [6];
  port6_t r;
  if (amiga) begin
    pin_of = '{2, 4, 1, 3, 0, 5};
  end else begin
    pin_of = '{3, 4, 1, 2, 0, 5};
  end
  for (int b = 0; b < 6; b++) begin
    r[b] = !pins[pin_of[b]];
  end
  return r;
endfunction

function automatic port6_t joy0_expect(input logic [1:0] mode, input logic [7:0] pins,
                                       input port6_t mouse);
  case (mode)
    2'd0:    return mouse;                 // usb
    2'd1:    return db9_decode(pins, 1'b0);
    2'd2:    return db9_decode(pins, 1'b1);
    default: return '0;                    // port off
  endcase
endfunction

// db9 joins the usb joystick only while the mouse sits on usb
function automatic joy5_t joy1_expect(input logic [1:0] mode, input logic [7:0] pins,
                                      input joy5_t joy);
  port6_t atari;
  atari = (mode == 2'd0) ? db9_decode(pins, 1'b0) : port6_t'(0);
  return joy | atari[4:0];
endfunction

function automatic kbd_row_t kbd_cols_expect(input kbd_sel_t sel, input kbd_row_t rows [KBD_ROWS]);
  kbd_row_t r;
  r = 8'hFF; // nothing selected reads idle
  for (int i = 0; i < KBD_ROWS; i++) begin
    if (sel[i] == 1'b0) begin
      r = r & rows[i];
    end
  end
  return r;
endfunction

// integer math, >>> on int floors like the hardware shift
function automatic sample16_t scale_sample(input sample15_t s, input logic [1:0] vol);
  int v;
  v = $signed(s);
  case (vol)
    2'd0:    v = 0;
    2'd1:    v = v >>> 2;
    2'd2:    v = v >>> 1;
    default: v = v;
  endcase
  return sample16_t'(v);
endfunction

function automatic word_addr_t scramble_addr(input word_addr_t a, input int count);
  return a ^ word_addr_t'((count % 4) << 3); // count lands on bits 4..3
endfunction

// one apb transfer, setup then access, driven on falling edges
task automatic bus_access(input bit write, input apb_addr_t addr, input apb_data_t wdata,
                          output apb_data_t rdata, output logic err);
  int waited;
  @(negedge clk32);
  apb.psel    = 1'b1;
  apb.penable = 1'b0;
  apb.pwrite  = write;
  apb.paddr   = addr;
  apb.pwdata  = wdata;
  @(negedge clk32);
  apb.penable = 1'b1;
  waited = 0;
  @(posedge clk32);
  while (!pready && waited < BUS_TIMEOUT) begin
    waited++;
    @(posedge clk32);
  end
  if (!pready) begin
    abort_run("timeout, the apb slave never raised pready");
  end
  rdata = prdata; // closing edge of the access phase
  err   = pslverr;
  @(negedge clk32);
  apb.psel    = 1'b0;
  apb.penable = 1'b0;
  apb.pwrite  = 1'b0;
endtask

task automatic bus_write(input apb_addr_t addr, input apb_data_t data);
  apb_data_t ignored;
  logic      ignored_err;
  bus_access(1'b1, addr, data, ignored, ignored_err);
endtask

task automatic bus_read(input apb_addr_t addr, output apb_data_t data, output logic err);
  bus_access(1'b0, addr, '0, data, err);
endtask

`endif

//--- testbench/tb_top.sv
// testbench for the atari st glue top
// drives random stimulus from a fixed seed and checks it against a reference model
`timescale 1ns/1ns
`default_nettype none

module tb_top
  import apb_pkg::*;
  import st_cfg_pkg::*;
();

  localparam int SD_WAIT = 200; // short sd wait for simulation

  logic        clk32;
  logic        rst;
  apb_req_t    apb;
  apb_data_t   prdata;
  logic        pready;
  logic        pslverr;
  logic [7:0]  io;
  kbd_sel_t    kbd_sel;
  port6_t      joy0;
  joy5_t       joy1;
  kbd_row_t    kbd_cols;
  sample15_t   audio_l_in;
  sample15_t   audio_r_in;
  sample16_t   audio_l;
  sample16_t   audio_r;
  logic        reset_button;
  logic        ram_ready;
  logic        flash_ready;
  logic [31:0] sd_img_size;
  word_addr_t  ram_addr_in;
  logic        st_resb;
  logic        sd_ready;
  word_addr_t  ram_addr_out;

  kbd_row_t kbd_model [KBD_ROWS]; // what the keyboard rows should hold
  int test_num;
  int test_checks;
  int test_errors;
  int total_checks;
  int total_errors;

  st_glue_top #(.SD_WAIT_CYCLES(SD_WAIT)) UUT (.*);

  initial begin
    clk32 = 1'b0;
    forever #50 clk32 = ~clk32; // 100 ns period
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    test_checks++;
    assert (got === exp) else begin
      test_errors++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    test_checks++;
    assert (cond) else begin
      test_errors++;
      $display("%s", what);
    end
  endtask

  task automatic end_test(input string name);
    $display("test %0d %s: %0d checks, %0d errors", test_num, name, test_checks, test_errors);
    total_checks += test_checks;
    total_errors += test_errors;
    test_num++;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic apply_reset();
    rst = 1'b1; // entered at time zero or on a falling edge
    repeat (5) @(negedge clk32); // 5 rising edges in reset
    rst = 1'b0;
  endtask

  `include "tb_model.svh"

  initial begin
    apb_data_t  data;
    apb_data_t  rd;
    logic       err;
    port6_t     mouse;
    joy5_t      joy;
    int         cycles;
    sys_cfg_t   cfg_w;
    apb_addr_t  bad_addr [5];
    void'($urandom(99));
    apb          = '0;
    io           = 8'hFF; // db9 idle with all pins released
    kbd_sel      = '1;
    audio_l_in   = '0;
    audio_r_in   = '0;
    reset_button = 1'b0;
    ram_ready    = 1'b1;
    flash_ready  = 1'b1;
    sd_img_size  = '0;
    ram_addr_in  = '0;
    rst          = 1'b1;
    test_num     = 1;
    test_checks  = 0;
    test_errors  = 0;
    total_checks = 0;
    total_errors = 0;
    apply_reset();

    // register access starting from reset values
    cfg_w = '{mouse_port: MP_USB, volume: VOL_FULL, sys_reset: 1'b0, coldboot: 1'b0};
    bus_read(CFG_OFS, rd, err);
    check_value("cfg", rd, 32'(cfg_w));
    check_value("pslverr", err, 32'h0);
    bus_read(HID_OFS, rd, err);
    check_value("hid", rd, 32'h0);
    check_value("pslverr", err, 32'h0);
    for (int i = 0; i < KBD_ROWS; i++) begin
      bus_read(apb_addr_t'(KBD_BASE + 4 * i), rd, err);
      check_value("kbd_row", rd, 32'hFF);
      check_value("pslverr", err, 32'h0);
    end
    data = $urandom;
    bus_write(CFG_OFS, data);
    bus_read(CFG_OFS, rd, err);
    check_value("cfg", rd, data & 32'h3F);
    check_value("pslverr", err, 32'h0);
    data = $urandom;
    bus_write(HID_OFS, data);
    bus_read(HID_OFS, rd, err);
    check_value("hid", rd, data & 32'h1F3F); // joystick 12..8, mouse 5..0
    check_value("pslverr", err, 32'h0);
    for (int i = 0; i < KBD_ROWS; i++) begin
      kbd_model[i] = kbd_row_t'($urandom);
      bus_write(apb_addr_t'(KBD_BASE + 4 * i), 32'(kbd_model[i]));
    end
    for (int i = 0; i < KBD_ROWS; i++) begin
      bus_read(apb_addr_t'(KBD_BASE + 4 * i), rd, err);
      check_value("kbd_row", rd, 32'(kbd_model[i]));
      check_value("pslverr", err, 32'h0);
    end
    bad_addr = '{8'h08, 8'h0C, 8'h12, 8'h4C, 8'hFC}; // gaps, misaligned, past row 14
    for (int i = 0; i < 5; i++) begin
      bus_read(bad_addr[i], rd, err);
      check_value("prdata", rd, 32'h0);
      check_true(err, $sformatf("no pslverr for unmapped address %h", bad_addr[i]));
    end
    end_test("register access");

    // port mapping over all four mouse_port codes
    for (int m = 0; m < 4; m++) begin
      bus_write(CFG_OFS, 32'({2'(m), VOL_FULL, 2'b00}));
      for (int n = 0; n < 50; n++) begin
        mouse = port6_t'($urandom);
        joy   = joy5_t'($urandom);
        bus_write(HID_OFS, 32'({joy, 2'b00, mouse}));
        io = 8'($urandom);
        @(posedge clk32);
        check_value("joy0", joy0, joy0_expect(2'(m), io, mouse));
        check_value("joy1", joy1, joy1_expect(2'(m), io, joy));
      end
    end
    end_test("port mapping");

    // keyboard scan with fresh rows
    for (int i = 0; i < KBD_ROWS; i++) begin
      kbd_model[i] = kbd_row_t'($urandom);
      bus_write(apb_addr_t'(KBD_BASE + 4 * i), 32'(kbd_model[i]));
    end
    for (int n = 0; n < 60; n++) begin
      @(negedge clk32);
      if (n == 0) begin
        kbd_sel = '1; // no row strobed
      end else if (n <= KBD_ROWS) begin
        kbd_sel = ~kbd_sel_t'(1 << (n - 1)); // one row at a time
      end else begin
        kbd_sel = kbd_sel_t'($urandom);
      end
      @(posedge clk32);
      check_value("kbd_cols", kbd_cols, kbd_cols_expect(kbd_sel, kbd_model));
    end
    kbd_sel = '1;
    end_test("keyboard scan");

    // volume with one cycle latency
    for (int v = 0; v < 4; v++) begin
      bus_write(CFG_OFS, 32'({MP_USB, 2'(v), 2'b00}));
      for (int n = 0; n < 30; n++) begin
        audio_l_in = (n == 0) ? 15'h4000 : sample15_t'($urandom); // most negative first
        audio_r_in = sample15_t'($urandom);
        @(negedge clk32);
        check_value("audio_l", audio_l, scale_sample(audio_l_in, 2'(v)));
        check_value("audio_r", audio_r, scale_sample(audio_r_in, 2'(v)));
        if (n == 0 && v != 0) begin
          check_true(audio_l[15], "full-scale negative sample lost its sign");
        end
      end
    end
    end_test("volume");

    // boot gate while the sd wait runs out
    sd_img_size = '0;
    apply_reset();
    cycles = 0;
    while (!sd_ready && cycles < 2 * SD_WAIT) begin
      check_true(!st_resb, "st_resb went high before sd_ready");
      @(negedge clk32);
      cycles++;
    end
    check_true(sd_ready, "timeout while waiting for sd_ready");
    check_true(cycles >= SD_WAIT && cycles <= SD_WAIT + 1,
               $sformatf("sd_ready rose after %0d cycles instead of %0d", cycles, SD_WAIT));
    check_value("st_resb", st_resb, 32'h1);
    apply_reset();
    sd_img_size = $urandom | 32'd1; // image mounted
    cycles = 0;
    while (!sd_ready && cycles < 2) begin
      @(negedge clk32);
      cycles++;
    end
    check_true(sd_ready, "sd_ready did not rise within two cycles of a nonzero image size");
    bus_write(CFG_OFS, 32'h0E); // sys_reset set
    check_value("st_resb", st_resb, 32'h0);
    bus_write(CFG_OFS, 32'h0C);
    check_value("st_resb", st_resb, 32'h1);
    reset_button = 1'b1;
    @(posedge clk32);
    check_value("st_resb", st_resb, 32'h0);
    @(negedge clk32);
    reset_button = 1'b0;
    @(posedge clk32);
    check_value("st_resb", st_resb, 32'h1);
    end_test("boot gate");

    // coldboot scramble counts up from zero after the last reset
    for (int k = 0; k < 4; k++) begin
      if (k > 0) begin
        bus_write(CFG_OFS, 32'h0D); // coldboot rising edge
        bus_write(CFG_OFS, 32'h0C);
      end
      for (int n = 0; n < 8; n++) begin
        @(negedge clk32);
        ram_addr_in = word_addr_t'($urandom);
        @(posedge clk32);
        check_value("ram_addr_out", ram_addr_out, scramble_addr(ram_addr_in, k));
      end
    end
    end_test("coldboot scramble");

    $display("tests %0d, checks %0d, errors %0d", test_num - 1, total_checks, total_errors);
    if (total_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
